/* design/icache_pkg.sv */
`default_nettype none

package icache_pkg;

  // Address and line geometry
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned InstrWidth     = 32;
  localparam int unsigned LineWordsWidth = 3;
  localparam int unsigned OffsetWidth    = LineWordsWidth + 2;
  localparam int unsigned LineAddrWidth  = AddrWidth - OffsetWidth;

  // Default cache shape, 2 ** SetsWidth sets of 2 ** WaysWidth ways
  localparam int unsigned SetsWidth = 4;
  localparam int unsigned WaysWidth = 1;

  // Address bits above the set index and the line offset
  function automatic int unsigned TagWidth(input int unsigned sets_width);
    return LineAddrWidth - sets_width;
  endfunction

  typedef enum logic [2:0] {
    FetchIdle,
    FetchFetch,
    FetchReplay,
    FetchFill,
    FetchFault,
    FetchFlush
  } fetch_state_e;

  typedef enum logic [1:0] {
    RefillIdle,
    RefillBus,
    RefillDone
  } refill_state_e;

endpackage

`default_nettype wire

/* design/icache_tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array #(
  parameter int unsigned SetsWidth = icache_pkg::SetsWidth,
  parameter int unsigned WaysWidth = icache_pkg::WaysWidth
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       rd_en_i,
  input  logic [SetsWidth-1:0]                       rd_set_i,
  input  logic [icache_pkg::TagWidth(SetsWidth)-1:0] rd_tag_i,
  input  logic                                       wr_en_i,
  input  logic [SetsWidth-1:0]                       wr_set_i,
  input  logic [WaysWidth-1:0]                       wr_way_i,
  input  logic [icache_pkg::TagWidth(SetsWidth)-1:0] wr_tag_i,
  input  logic                                       clr_en_i,
  input  logic [SetsWidth-1:0]                       clr_set_i,
  input  logic                                       victim_use_i,
  output logic                                       hit_o,
  output logic [WaysWidth-1:0]                       hit_way_o,
  output logic [WaysWidth-1:0]                       victim_way_o
);
  import icache_pkg::*;

  localparam int unsigned TagW    = TagWidth(SetsWidth);
  localparam int unsigned NumWays = 2 ** WaysWidth;
  localparam int unsigned NumSets = 2 ** SetsWidth;

  logic [TagW-1:0]      tag_mem   [NumWays][NumSets];
  logic [NumWays-1:0]   valid_mem [NumSets];
  logic [TagW-1:0]      rd_tags_q [NumWays];
  logic [NumWays-1:0]   rd_valid_q;
  logic [TagW-1:0]      cmp_tag_q;
  logic [SetsWidth-1:0] rd_set_q;
  logic [WaysWidth-1:0] rr_q;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[wr_way_i][wr_set_i] <= wr_tag_i;
    end
  end

  // A miss drops its victim at once, so a failed refill leaves it invalid
  always_ff @(posedge clk_i) begin
    if (clr_en_i) begin
      valid_mem[clr_set_i] <= '0;
    end
    if (victim_use_i) begin
      valid_mem[rd_set_q][victim_way_o] <= 1'b0;
    end
    if (wr_en_i) begin
      valid_mem[wr_set_i][wr_way_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      for (int w = 0; w < NumWays; w++) begin
        rd_tags_q[w]  <= tag_mem[w][rd_set_i];
        rd_valid_q[w] <= valid_mem[rd_set_i][w];
      end
      cmp_tag_q <= rd_tag_i;
      rd_set_q  <= rd_set_i;
    end
  end

  // Round-robin fallback pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (victim_use_i) begin
      rr_q <= rr_q + 1'b1;
    end
  end

  // Lowest way wins for both the hit and the empty-way choice
  always_comb begin
    hit_o        = 1'b0;
    hit_way_o    = '0;
    victim_way_o = rr_q;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!rd_valid_q[w]) begin
        victim_way_o = WaysWidth'(w);
      end
      if (rd_valid_q[w] && rd_tags_q[w] == cmp_tag_q) begin
        hit_o     = 1'b1;
        hit_way_o = WaysWidth'(w);
      end
    end
  end

endmodule

`default_nettype wire

/* design/icache_data_array.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_data_array #(
  parameter int unsigned SetsWidth = icache_pkg::SetsWidth,
  parameter int unsigned WaysWidth = icache_pkg::WaysWidth
) (
  input  logic                                 clk_i,
  input  logic                                 rd_en_i,
  input  logic [SetsWidth-1:0]                 rd_set_i,
  input  logic [icache_pkg::LineWordsWidth-1:0] rd_word_i,
  input  logic [WaysWidth-1:0]                 rd_way_i,
  input  logic                                 wr_en_i,
  input  logic [SetsWidth-1:0]                 wr_set_i,
  input  logic [icache_pkg::LineWordsWidth-1:0] wr_word_i,
  input  logic [WaysWidth-1:0]                 wr_way_i,
  input  logic [icache_pkg::InstrWidth-1:0]     wr_data_i,
  output logic [icache_pkg::InstrWidth-1:0]     rd_data_o
);
  import icache_pkg::*;

  localparam int unsigned NumWays  = 2 ** WaysWidth;
  localparam int unsigned NumWords = 2 ** (SetsWidth + LineWordsWidth);

  logic [InstrWidth-1:0] data_mem [NumWays][NumWords];
  logic [InstrWidth-1:0] rd_q     [NumWays];

  // Every way is read, the hit way picks one afterwards
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      data_mem[wr_way_i][{wr_set_i, wr_word_i}] <= wr_data_i;
    end
    if (rd_en_i) begin
      for (int w = 0; w < NumWays; w++) begin
        rd_q[w] <= data_mem[w][{rd_set_i, rd_word_i}];
      end
    end
  end

  assign rd_data_o = rd_q[rd_way_i];

endmodule

`default_nettype wire

/* design/icache_refill.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_refill #(
  parameter int unsigned WaysWidth = icache_pkg::WaysWidth
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  start_i,
  input  logic [icache_pkg::LineAddrWidth-1:0]  line_addr_i,
  input  logic [WaysWidth-1:0]                  way_i,
  output logic                                  wb_cyc_o,
  output logic                                  wb_stb_o,
  output logic [icache_pkg::AddrWidth-1:0]      wb_adr_o,
  input  logic [icache_pkg::InstrWidth-1:0]     wb_dat_i,
  input  logic                                  wb_ack_i,
  input  logic                                  wb_err_i,
  output logic                                  data_wr_en_o,
  output logic [icache_pkg::LineWordsWidth-1:0] data_wr_word_o,
  output logic [icache_pkg::InstrWidth-1:0]     data_wr_data_o,
  output logic [WaysWidth-1:0]                  wr_way_o,
  output logic                                  tag_wr_en_o,
  output logic                                  done_o,
  output logic                                  err_o
);
  import icache_pkg::*;

  refill_state_e             state_q;
  logic                      stb_q;
  logic [LineWordsWidth-1:0] word_q;
  logic [WaysWidth-1:0]      way_q;

  // One classic cycle per word, CYC and STB move together
  assign wb_cyc_o = stb_q;
  assign wb_stb_o = stb_q;
  assign wb_adr_o = {line_addr_i, word_q, 2'b00};

  assign err_o          = stb_q && wb_err_i;
  assign data_wr_en_o   = stb_q && wb_ack_i && !wb_err_i;
  assign data_wr_word_o = word_q;
  assign data_wr_data_o = wb_dat_i;
  assign wr_way_o       = way_q;

  // Tag goes in after the last word, an error beat ends the line early
  assign tag_wr_en_o = state_q == RefillDone;
  assign done_o      = tag_wr_en_o || err_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RefillIdle;
      stb_q   <= 1'b0;
      word_q  <= '0;
    end else begin
      case (state_q)
        RefillIdle: begin
          if (start_i) begin
            state_q <= RefillBus;
            stb_q   <= 1'b1;
            word_q  <= '0;
          end
        end
        RefillBus: begin
          if (err_o) begin
            stb_q   <= 1'b0;
            state_q <= RefillIdle;
          end else if (data_wr_en_o) begin
            // Idle cycle between words
            stb_q  <= 1'b0;
            word_q <= word_q + 1'b1;
            if (&word_q) begin
              state_q <= RefillDone;
            end
          end else begin
            stb_q <= 1'b1;
          end
        end
        default: state_q <= RefillIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      way_q <= way_i;
    end
  end

endmodule

`default_nettype wire

/* design/icache_flush.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_flush #(
  parameter int unsigned SetsWidth = icache_pkg::SetsWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  output logic                 clr_en_o,
  output logic [SetsWidth-1:0] clr_set_o,
  output logic                 done_o
);

  logic                 active_q;
  logic [SetsWidth-1:0] set_q;

  // One set per cycle, all of its ways at once
  assign clr_en_o  = active_q;
  assign clr_set_o = set_q;
  assign done_o    = active_q && (&set_q);

  // Sweep starts straight out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b1;
      set_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      set_q    <= '0;
    end else if (active_q) begin
      set_q <= set_q + 1'b1;
      if (&set_q) begin
        active_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/icache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl #(
  parameter int unsigned SetsWidth = icache_pkg::SetsWidth,
  parameter int unsigned WaysWidth = icache_pkg::WaysWidth
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       req_valid_i,
  input  logic [icache_pkg::AddrWidth-1:0]           req_addr_i,
  input  logic                                       req_flush_i,
  output logic                                       req_ready_o,
  output logic                                       resp_valid_o,
  output logic [icache_pkg::InstrWidth-1:0]          resp_instr_o,
  output logic                                       resp_fault_o,
  output logic                                       rd_en_o,
  output logic [SetsWidth-1:0]                       rd_set_o,
  output logic [icache_pkg::LineWordsWidth-1:0]      rd_word_o,
  output logic [icache_pkg::TagWidth(SetsWidth)-1:0] rd_tag_o,
  input  logic                                       hit_i,
  input  logic [WaysWidth-1:0]                       hit_way_i,
  input  logic [WaysWidth-1:0]                       victim_way_i,
  output logic                                       victim_use_o,
  input  logic [icache_pkg::InstrWidth-1:0]          rd_data_i,
  output logic                                       refill_start_o,
  output logic [icache_pkg::LineAddrWidth-1:0]       refill_line_o,
  output logic [WaysWidth-1:0]                       refill_way_o,
  input  logic                                       refill_done_i,
  input  logic                                       refill_err_i,
  output logic                                       flush_start_o,
  input  logic                                       flush_done_i
);
  import icache_pkg::*;

  localparam int unsigned TagW = TagWidth(SetsWidth);

  fetch_state_e         state_q;
  logic [AddrWidth-1:0] addr_q;
  logic [AddrWidth-1:0] rd_addr;
  logic [WaysWidth-1:0] way_q;
  logic                 accept;
  logic                 start_q;
  logic                 flush_req_q;

  //////////////////////////////
  // Request and array read

  assign req_ready_o   = state_q == FetchIdle;
  assign accept        = req_ready_o && req_valid_i;
  assign flush_start_o = accept && req_flush_i;

  // New request reads straight away, a replay uses the held address
  assign rd_addr   = (state_q == FetchIdle) ? req_addr_i : addr_q;
  assign rd_en_o   = (accept && !req_flush_i) || state_q == FetchReplay;
  assign rd_word_o = rd_addr[2 +: LineWordsWidth];
  assign rd_set_o  = rd_addr[OffsetWidth +: SetsWidth];
  assign rd_tag_o  = rd_addr[AddrWidth-1 -: TagW];

  //////////////////////////////
  // Response and miss handling

  assign resp_valid_o = (state_q == FetchFetch && hit_i) || state_q == FetchFault;
  assign resp_fault_o = state_q == FetchFault;
  assign resp_instr_o = rd_data_i;

  assign victim_use_o   = state_q == FetchFetch && !hit_i;
  assign refill_start_o = start_q;
  assign refill_line_o  = addr_q[AddrWidth-1:OffsetWidth];
  assign refill_way_o   = way_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FetchFlush;
      start_q     <= 1'b0;
      flush_req_q <= 1'b0;
    end else begin
      // Refill starts once the victim way is held
      start_q <= victim_use_o;
      case (state_q)
        FetchIdle: begin
          if (accept && req_flush_i) begin
            state_q     <= FetchFlush;
            flush_req_q <= 1'b1;
          end else if (accept) begin
            state_q <= FetchFetch;
          end
        end
        FetchFetch: begin
          if (hit_i) begin
            state_q <= FetchIdle;
          end else begin
            state_q <= FetchFill;
          end
        end
        FetchReplay: state_q <= FetchFetch;
        FetchFill: begin
          if (refill_done_i && refill_err_i) begin
            state_q <= FetchFault;
          end else if (refill_done_i) begin
            state_q <= FetchReplay;
          end
        end
        FetchFlush: begin
          // Reset sweep has no fetch behind it
          if (flush_done_i && flush_req_q) begin
            state_q <= FetchReplay;
          end else if (flush_done_i) begin
            state_q <= FetchIdle;
          end
          if (flush_done_i) begin
            flush_req_q <= 1'b0;
          end
        end
        default: state_q <= FetchIdle;
      endcase
    end
  end

  // Way of the last lookup, the victim when it missed
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= req_addr_i;
    end
    if (state_q == FetchFetch) begin
      way_q <= hit_i ? hit_way_i : victim_way_i;
    end
  end

endmodule

`default_nettype wire

/* design/icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
  parameter int unsigned SetsWidth = icache_pkg::SetsWidth,
  parameter int unsigned WaysWidth = icache_pkg::WaysWidth
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_valid_i,
  input  logic [icache_pkg::AddrWidth-1:0]  req_addr_i,
  input  logic                              req_flush_i,
  output logic                              req_ready_o,
  output logic                              resp_valid_o,
  output logic [icache_pkg::InstrWidth-1:0] resp_instr_o,
  output logic                              resp_fault_o,
  output logic                              wb_cyc_o,
  output logic                              wb_stb_o,
  output logic [icache_pkg::AddrWidth-1:0]  wb_adr_o,
  input  logic [icache_pkg::InstrWidth-1:0] wb_dat_i,
  input  logic                              wb_ack_i,
  input  logic                              wb_err_i
);
  import icache_pkg::*;

  localparam int unsigned TagW = TagWidth(SetsWidth);

  // Lookup path
  logic                      rd_en;
  logic [SetsWidth-1:0]      rd_set;
  logic [LineWordsWidth-1:0] rd_word;
  logic [TagW-1:0]           rd_tag;
  logic                      hit;
  logic [WaysWidth-1:0]      hit_way;
  logic [WaysWidth-1:0]      victim_way;
  logic                      victim_use;
  logic [InstrWidth-1:0]     rd_data;

  // Refill and flush
  logic                      refill_start;
  logic [LineAddrWidth-1:0]  refill_line;
  logic [WaysWidth-1:0]      refill_way;
  logic                      refill_done;
  logic                      refill_err;
  logic                      data_wr_en;
  logic [LineWordsWidth-1:0] data_wr_word;
  logic [InstrWidth-1:0]     data_wr_data;
  logic [WaysWidth-1:0]      wr_way;
  logic                      tag_wr_en;
  logic                      flush_start;
  logic                      flush_done;
  logic                      clr_en;
  logic [SetsWidth-1:0]      clr_set;

  icache_ctrl #(
    .SetsWidth (SetsWidth),
    .WaysWidth (WaysWidth)
  ) u_ctrl (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_addr_i,
    .req_flush_i,
    .req_ready_o,
    .resp_valid_o,
    .resp_instr_o,
    .resp_fault_o,
    .rd_en_o        (rd_en),
    .rd_set_o       (rd_set),
    .rd_word_o      (rd_word),
    .rd_tag_o       (rd_tag),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .victim_use_o   (victim_use),
    .rd_data_i      (rd_data),
    .refill_start_o (refill_start),
    .refill_line_o  (refill_line),
    .refill_way_o   (refill_way),
    .refill_done_i  (refill_done),
    .refill_err_i   (refill_err),
    .flush_start_o  (flush_start),
    .flush_done_i   (flush_done)
  );

  icache_tag_array #(
    .SetsWidth (SetsWidth),
    .WaysWidth (WaysWidth)
  ) u_tag_array (
    .clk_i,
    .rst_ni,
    .rd_en_i      (rd_en),
    .rd_set_i     (rd_set),
    .rd_tag_i     (rd_tag),
    .wr_en_i      (tag_wr_en),
    .wr_set_i     (refill_line[SetsWidth-1:0]),
    .wr_way_i     (wr_way),
    .wr_tag_i     (refill_line[LineAddrWidth-1:SetsWidth]),
    .clr_en_i     (clr_en),
    .clr_set_i    (clr_set),
    .victim_use_i (victim_use),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
  );

  icache_data_array #(
    .SetsWidth (SetsWidth),
    .WaysWidth (WaysWidth)
  ) u_data_array (
    .clk_i,
    .rd_en_i   (rd_en),
    .rd_set_i  (rd_set),
    .rd_word_i (rd_word),
    .rd_way_i  (hit_way),
    .wr_en_i   (data_wr_en),
    .wr_set_i  (refill_line[SetsWidth-1:0]),
    .wr_word_i (data_wr_word),
    .wr_way_i  (wr_way),
    .wr_data_i (data_wr_data),
    .rd_data_o (rd_data)
  );

  icache_refill #(
    .WaysWidth (WaysWidth)
  ) u_refill (
    .clk_i,
    .rst_ni,
    .start_i        (refill_start),
    .line_addr_i    (refill_line),
    .way_i          (refill_way),
    .wb_cyc_o,
    .wb_stb_o,
    .wb_adr_o,
    .wb_dat_i,
    .wb_ack_i,
    .wb_err_i,
    .data_wr_en_o   (data_wr_en),
    .data_wr_word_o (data_wr_word),
    .data_wr_data_o (data_wr_data),
    .wr_way_o       (wr_way),
    .tag_wr_en_o    (tag_wr_en),
    .done_o         (refill_done),
    .err_o          (refill_err)
  );

  icache_flush #(
    .SetsWidth (SetsWidth)
  ) u_flush (
    .clk_i,
    .rst_ni,
    .start_i   (flush_start),
    .clr_en_o  (clr_en),
    .clr_set_o (clr_set),
    .done_o    (flush_done)
  );

endmodule

`default_nettype wire

/* verif/icache_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_properties (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             req_ready_i,
  input logic                             resp_valid_i,
  input logic                             wb_cyc_i,
  input logic                             wb_stb_i,
  input logic [icache_pkg::AddrWidth-1:0] wb_adr_i,
  input logic                             wb_ack_i,
  input logic                             wb_err_i
);

  // Count of failed assertions
  int unsigned fail_count = 0;

  // Classic cycle framing with a strobe only inside a cycle
  property stb_inside_cyc;
    @(posedge clk_i) disable iff (!rst_ni) wb_stb_i |-> wb_cyc_i;
  endproperty

  // Address held while the slave stretches the beat
  property adr_held_while_waiting;
    @(posedge clk_i) disable iff (!rst_ni)
      (wb_stb_i && !wb_ack_i && !wb_err_i) |=> (wb_stb_i && $stable(wb_adr_i));
  endproperty

  property resp_single_pulse;
    @(posedge clk_i) disable iff (!rst_ni) resp_valid_i |=> !resp_valid_i;
  endproperty

  // No new request while a refill owns the bus
  property no_ready_during_refill;
    @(posedge clk_i) disable iff (!rst_ni) wb_cyc_i |-> !req_ready_i;
  endproperty

  a_stb_inside_cyc: assert property (stb_inside_cyc)
    else begin
      fail_count++;
      $error("wb_stb_o high without wb_cyc_o");
    end

  a_adr_held: assert property (adr_held_while_waiting)
    else begin
      fail_count++;
      $error("wb_adr_o changed or strobe dropped before the acknowledge");
    end

  a_resp_pulse: assert property (resp_single_pulse)
    else begin
      fail_count++;
      $error("resp_valid_o high for more than one cycle");
    end

  a_no_ready: assert property (no_ready_during_refill)
    else begin
      fail_count++;
      $error("req_ready_o high while wb_cyc_o is high");
    end

endmodule

`default_nettype wire

/* verif/icache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  localparam int unsigned CacheSetsWidth = 4;
  localparam int unsigned CacheWaysWidth = 1;
  localparam int unsigned LineWords      = 2 ** LineWordsWidth;
  localparam int unsigned LineBytes      = 4 * LineWords;
  localparam int unsigned ResetCycles    = 16;
  localparam logic [31:0] RandSeed       = 32'hec5d421f;
  localparam string       PatternFile    = "verif/icache_patterns.txt";

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_valid_i;
  logic [AddrWidth-1:0]  req_addr_i;
  logic                  req_flush_i;
  logic                  req_ready_o;
  logic                  resp_valid_o;
  logic [InstrWidth-1:0] resp_instr_o;
  logic                  resp_fault_o;
  logic                  wb_cyc_o;
  logic                  wb_stb_o;
  logic [AddrWidth-1:0]  wb_adr_o;
  logic [InstrWidth-1:0] wb_dat_i;
  logic                  wb_ack_i;
  logic                  wb_err_i;

  // Request table from the pattern file
  logic [AddrWidth-1:0] pat_addr  [$];
  bit                   pat_flush [$];
  bit                   pat_hit   [$];
  bit                   pat_fault [$];

  // Strobe addresses seen by the memory since the last request
  logic [AddrWidth-1:0] bus_log [$];

  int unsigned errors;
  int unsigned checks;
  int unsigned timeout_cycles;
  int unsigned cycle_cnt;

  icache_top #(
    .SetsWidth (CacheSetsWidth),
    .WaysWidth (CacheWaysWidth)
  ) u_dut (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_addr_i,
    .req_flush_i,
    .req_ready_o,
    .resp_valid_o,
    .resp_instr_o,
    .resp_fault_o,
    .wb_cyc_o,
    .wb_stb_o,
    .wb_adr_o,
    .wb_dat_i,
    .wb_ack_i,
    .wb_err_i
  );

  bind icache_top icache_properties u_properties (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_ready_i  (req_ready_o),
    .resp_valid_i (resp_valid_o),
    .wb_cyc_i     (wb_cyc_o),
    .wb_stb_i     (wb_stb_o),
    .wb_adr_i     (wb_adr_o),
    .wb_ack_i     (wb_ack_i),
    .wb_err_i     (wb_err_i)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  //////////////////////////////
  // Wishbone memory model

  // Word at an address is its inverse, bit 31 set means a bus error
  initial begin : memory_model
    int unsigned wait_cnt;
    bit          busy;
    wb_dat_i = '0;
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    busy     = 1'b0;
    wait_cnt = 0;
    void'($urandom(RandSeed));
    forever begin
      @(negedge clk_i);
      if (wb_ack_i || wb_err_i) begin
        wb_ack_i = 1'b0;
        wb_err_i = 1'b0;
      end else if (wb_cyc_o && wb_stb_o) begin
        if (!busy) begin
          busy     = 1'b1;
          wait_cnt = $urandom % 4;
          bus_log.push_back(wb_adr_o);
        end
        if (wait_cnt == 0) begin
          busy     = 1'b0;
          wb_dat_i = ~wb_adr_o;
          wb_err_i = wb_adr_o[AddrWidth-1];
          wb_ack_i = !wb_adr_o[AddrWidth-1];
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  //////////////////////////////
  // Helpers

  task automatic read_patterns(output bit ok);
    int                   fd;
    int                   code;
    int                   hit_f;
    int                   fault_f;
    bit                   bad;
    logic [63:0]          tok;
    logic [8*100-1:0]     rest;
    logic [AddrWidth-1:0] addr;
    ok  = 1'b0;
    bad = 1'b0;
    fd  = $fopen(PatternFile, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if (code == 1 && tok == "#") begin
          code = $fgets(rest, fd);
        end else if (code == 1) begin
          code = $fscanf(fd, "%h %d %d", addr, hit_f, fault_f);
          if (code != 3 || (tok != "fetch" && tok != "flush")) begin
            bad = 1'b1;
            $display("Pattern file line after entry %0d cannot be parsed", pat_addr.size());
          end else begin
            pat_flush.push_back(tok == "flush");
            pat_addr.push_back(addr);
            pat_hit.push_back(hit_f != 0);
            pat_fault.push_back(fault_f != 0);
          end
        end
      end
      $fclose(fd);
      ok = !bad && pat_addr.size() > 0;
    end
  endtask

  // Bus cycles must walk the line from its first word upward
  function automatic bit line_walk_ok(input logic [AddrWidth-1:0] line_base,
                                      input int unsigned beats);
    if (bus_log.size() != beats) begin
      return 1'b0;
    end
    for (int w = 0; w < beats; w++) begin
      if (bus_log[w] !== line_base + AddrWidth'(4 * w)) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic apply_reset();
    int unsigned sweep;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    checks++;
    assert (!resp_valid_o && !resp_fault_o && !wb_cyc_o && !wb_stb_o) else begin
      errors++;
      $display("ERR %0t: response or bus outputs active during reset", $time);
    end
    rst_ni = 1'b1;
    sweep  = 0;
    while (!req_ready_o) begin
      @(negedge clk_i);
      sweep++;
    end
    checks++;
    assert (sweep == 2 ** CacheSetsWidth) else begin
      errors++;
      $display("ERR %0t: req_ready_o low for %0d cycles after reset, expected %0d",
               $time, sweep, 2 ** CacheSetsWidth);
    end
  endtask

  task automatic run_request(input bit flush, input logic [AddrWidth-1:0] addr,
                             input bit exp_hit, input bit exp_fault);
    int unsigned          lat;
    int unsigned          beats;
    logic [AddrWidth-1:0] line_base;
    line_base = addr & ~AddrWidth'(LineBytes - 1);
    beats     = exp_hit ? 0 : (exp_fault ? 1 : LineWords);
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    bus_log.delete();
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_flush_i = flush;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    req_flush_i = 1'b0;
    lat = 1;
    while (!resp_valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    checks++;
    assert ((lat == 1) == exp_hit) else begin
      errors++;
      $display("ERR %0t: fetch %h answered after %0d cycles, expected hit %0b",
               $time, addr, lat, exp_hit);
    end
    checks++;
    assert (resp_fault_o == exp_fault) else begin
      errors++;
      $display("ERR %0t: fetch %h fault %0b, expected %0b", $time, addr, resp_fault_o, exp_fault);
    end
    if (!exp_fault) begin
      checks++;
      assert (resp_instr_o == ~addr) else begin
        errors++;
        $display("ERR %0t: fetch %h returned %h, expected %h", $time, addr, resp_instr_o, ~addr);
      end
    end
    checks++;
    assert (line_walk_ok(line_base, beats)) else begin
      errors++;
      $display("ERR %0t: fetch %h made %0d bus cycles, expected %0d in order from %h",
               $time, addr, bus_log.size(), beats, line_base);
    end
  endtask

  task automatic print_counts();
    $display("Checks: %0d, errors: %0d, property failures: %0d",
             checks, errors, u_dut.u_properties.fail_count);
  endtask

  //////////////////////////////
  // Run control

  initial begin : watchdog
    cycle_cnt = 0;
    @(posedge rst_ni);
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: patterns not finished after %0d cycles", cycle_cnt);
    print_counts();
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    bit loaded;
    errors         = 0;
    checks         = 0;
    timeout_cycles = 0;
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_addr_i     = '0;
    req_flush_i    = 1'b0;
    read_patterns(loaded);
    // Worst case per request is a slow line refill behind a full sweep
    timeout_cycles = pat_addr.size() * (LineWords * 5 + 2 ** CacheSetsWidth + 20);
    if (loaded) begin
      apply_reset();
      for (int i = 0; i < pat_addr.size(); i++) begin
        run_request(pat_flush[i], pat_addr[i], pat_hit[i], pat_fault[i]);
      end
    end else begin
      errors++;
      $display("Pattern file %s is missing, empty or malformed", PatternFile);
    end
    print_counts();
    if (errors == 0 && u_dut.u_properties.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/icache_patterns.txt */
# op address hit fault, address in hex, hit and fault as 0 or 1
# op is fetch, or flush to sweep the cache before the fetch
fetch 00001000 0 0
fetch 0000101c 1 0
fetch 00001008 1 0
fetch 00002000 0 0
fetch 00003004 0 0
fetch 00002010 1 0
fetch 00001004 0 0
fetch 00003000 1 0
fetch 80000040 0 1
fetch 80000044 0 1
fetch 00000520 0 0
flush 00001008 0 0
fetch 00000524 0 0
fetch 00001010 1 0
fetch 00003008 0 0
fetch 0000052c 1 0

/* flist.f */
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_refill.sv
design/icache_flush.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/icache_properties.sv
verif/icache_tb.sv
